// File: Bender.yml
package:
  name: bicubic_vert_filter

sources:
  - design/bicubic_pkg.sv
  - design/bicubic_ifs.sv
  - design/bicubic_coef_regs.sv
  - design/bicubic_mult_stage2.sv
  - design/bicubic_sum_stage2.sv
  - design/bicubic_vert_filter.sv
  - target: simulation
    files:
      - bench/tb_bicubic_vert_filter.sv

// File: bench/tb_bicubic_vert_filter.sv
`default_nettype none

module tb_bicubic_vert_filter import bicubic_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_SEED    = 32'ha75f_295e;
    localparam int PIPE_EDGES   = MULT_LATENCY + SUM_LATENCY;
    // near the largest magnitude whose product with 1981 still fits 32 bits
    localparam int CLIP_MAG     = 1_084_000;
    localparam int SMALL_MAG    = 1 << 17;
    localparam int NUM_BASIC    = 200;
    localparam int NUM_CLIP     = 40;
    localparam int NUM_STALL    = 200;
    localparam int NUM_REPROG   = 200;
    localparam int NUM_PRE_RST  = 20;
    localparam int NUM_POST_RST = 100;
    localparam int DRAIN_EDGES  = 8;
    localparam int PLANNED_CYCLES = 2 + NUM_BASIC + NUM_CLIP + NUM_STALL + NUM_REPROG
                                  + NUM_PRE_RST + 3 + NUM_POST_RST + DRAIN_EDGES;
    localparam int CYCLE_LIMIT  = PLANNED_CYCLES + 100;

    logic         clk;
    logic         rst;
    logic         ena;
    logic         in_valid;
    phase_t       phase;
    sample_t      pix0;
    sample_t      pix1;
    sample_t      pix2;
    sample_t      pix3;
    logic         cfg_we;
    phase_t       cfg_phase;
    tap_t         cfg_tap;
    weight_code_t cfg_code;
    logic         out_valid;
    pixel_t       out_pixel;

    // weights by code, and the reset table flattened as phase*4 + tap
    int weight_val [8]     = '{-21, -135, -147, -225, 235, 873, 1535, 1981};
    int default_codes [16] = '{0, 7, 4, 2, 1, 5, 6, 3, 3, 6, 5, 1, 2, 4, 7, 0};
    int model_codes [16];

    int exp_pix [$];
    int exp_age [$];
    bit rst_seen;
    int cycle_count;

    bicubic_vert_filter uut (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .in_valid  (in_valid),
        .phase     (phase),
        .pix0      (pix0),
        .pix1      (pix1),
        .pix2      (pix2),
        .pix3      (pix3),
        .cfg_we    (cfg_we),
        .cfg_phase (cfg_phase),
        .cfg_tap   (cfg_tap),
        .cfg_code  (cfg_code),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s got %0d expected %0d", $time, what, got, expected);
            end_in_failure();
        end
    endtask

    function automatic int expected_pixel(input int ph, input int s0, input int s1,
                                          input int s2, input int s3);
        longint acc;
        acc = longint'(s0) * weight_val[model_codes[ph*4]]
            + longint'(s1) * weight_val[model_codes[ph*4+1]]
            + longint'(s2) * weight_val[model_codes[ph*4+2]]
            + longint'(s3) * weight_val[model_codes[ph*4+3]];
        // round to nearest, then scale down by 2048
        acc = (acc + 1024) >>> 11;
        if (acc < 0)
            return 0;
        if (acc > 255)
            return 255;
        return int'(acc);
    endfunction

    function automatic sample_t random_sample(input bit clip);
        if (clip)
            return ($urandom_range(0, 1) != 0) ? sample_t'(CLIP_MAG) : sample_t'(-CLIP_MAG);
        return sample_t'(int'($urandom_range(0, 2 * SMALL_MAG)) - SMALL_MAG);
    endfunction

    // reference model, runs on the values present before each edge
    always @(posedge clk) begin : model
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            end_in_failure();
        end
        if (rst) begin
            exp_pix.delete();
            exp_age.delete();
            for (int i = 0; i < 16; i++)
                model_codes[i] = default_codes[i];
            rst_seen = 1'b1;
        end else begin
            if (rst_seen) begin
                check_value("out_valid after reset", out_valid, 1'b0);
                rst_seen = 1'b0;
            end
            if (ena) begin
                if (out_valid === 1'b1) begin
                    if (exp_pix.size() == 0) begin
                        $display("out_valid high at %0d ns with no sample in flight", $time);
                        end_in_failure();
                    end
                    check_value("latency in enabled edges", exp_age[0], PIPE_EDGES);
                    check_value("out_pixel", out_pixel, exp_pix[0]);
                    void'(exp_pix.pop_front());
                    void'(exp_age.pop_front());
                end else if (exp_age.size() != 0 && exp_age[0] >= PIPE_EDGES) begin
                    $display("sample taken earlier never came out by %0d ns", $time);
                    end_in_failure();
                end
                for (int i = 0; i < exp_age.size(); i++)
                    exp_age[i]++;
                if (in_valid) begin
                    exp_pix.push_back(expected_pixel(int'(phase), int'(pix0), int'(pix1),
                                                     int'(pix2), int'(pix3)));
                    // the edge that takes the sample counts as the first
                    exp_age.push_back(1);
                end
            end
            // table write lands after this edge's sample used the old entry
            if (cfg_we)
                model_codes[int'(cfg_phase)*4 + int'(cfg_tap)] = int'(cfg_code);
        end
    end

    task automatic send(input int cycles, input int valid_pct, input int stall_pct,
                        input int cfg_pct, input bit clip);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            ena       <= ($urandom_range(0, 99) >= stall_pct);
            in_valid  <= ($urandom_range(0, 99) < valid_pct);
            phase     <= phase_t'($urandom_range(0, 3));
            pix0      <= random_sample(clip);
            pix1      <= random_sample(clip);
            pix2      <= random_sample(clip);
            pix3      <= random_sample(clip);
            cfg_we    <= ($urandom_range(0, 99) < cfg_pct);
            cfg_phase <= phase_t'($urandom_range(0, 3));
            cfg_tap   <= tap_t'($urandom_range(0, 3));
            cfg_code  <= weight_code_t'($urandom_range(0, 7));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst    <= 1'b1;
        cfg_we <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        ena      <= 1'b1;
        in_valid <= 1'b0;
        cfg_we   <= 1'b0;
        // last sample leaves within PIPE_EDGES enabled edges
        repeat (PIPE_EDGES + 1) @(posedge clk);
        @(negedge clk);
    endtask

    initial begin
        rst         = 1'b1;
        ena         = 1'b0;
        in_valid    = 1'b0;
        phase       = '0;
        pix0        = '0;
        pix1        = '0;
        pix2        = '0;
        pix3        = '0;
        cfg_we      = 1'b0;
        cfg_phase   = '0;
        cfg_tap     = '0;
        cfg_code    = '0;
        rst_seen    = 1'b0;
        cycle_count = 0;
        void'($urandom(RAND_SEED));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        send(NUM_BASIC, 100, 0, 0, 1'b0);
        send(NUM_CLIP, 100, 0, 0, 1'b1);
        // ena low about a third of the time
        send(NUM_STALL, 75, 33, 0, 1'b0);
        send(NUM_REPROG, 75, 15, 25, 1'b0);
        // reset with samples still in the pipe
        send(NUM_PRE_RST, 100, 0, 25, 1'b0);
        apply_reset();
        send(NUM_POST_RST, 100, 0, 0, 1'b0);
        drain();

        if (exp_pix.size() != 0) begin
            $display("%0d samples still pending at the end of the run", exp_pix.size());
            end_in_failure();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/bicubic_coef_regs.sv
`default_nettype none

module bicubic_coef_regs import bicubic_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         cfg_we,
    input  wire phase_t       cfg_phase,
    input  wire tap_t         cfg_tap,
    input  wire weight_code_t cfg_code,
    tap_code_if.tbl           codes
);

    weight_code_t table_q [NUM_PHASES][NUM_TAPS];

    always_ff @(posedge clk) begin
        if (rst) begin
            table_q <= DEFAULT_CODES;
        end else if (cfg_we) begin
            // one entry per write
            table_q[cfg_phase][cfg_tap] <= cfg_code;
        end
    end

    // combinational read of the requested phase
    assign codes.code0 = table_q[codes.phase][0];
    assign codes.code1 = table_q[codes.phase][1];
    assign codes.code2 = table_q[codes.phase][2];
    assign codes.code3 = table_q[codes.phase][3];

    // a write with an unknown code would poison the table until the next reset
    a_cfg_code_known : assert property (
        @(posedge clk) disable iff (rst)
        cfg_we |-> !$isunknown({cfg_phase, cfg_tap, cfg_code})
    ) else $error("coef table written with unknown phase, tap or code");

endmodule

`default_nettype wire

// File: design/bicubic_ifs.sv
`default_nettype none

// phase request out, four tap codes back
interface tap_code_if import bicubic_pkg::*; ();
    phase_t       phase;
    weight_code_t code0;
    weight_code_t code1;
    weight_code_t code2;
    weight_code_t code3;

    modport filter (output phase, input code0, code1, code2, code3);
    modport tbl    (input phase, output code0, code1, code2, code3);
endinterface

// products of the four taps plus the aligned valid
interface product_if import bicubic_pkg::*; ();
    product_t p0;
    product_t p1;
    product_t p2;
    product_t p3;
    logic     valid;

    modport sum (input p0, p1, p2, p3, valid);
endinterface

`default_nettype wire

// File: design/bicubic_mult_stage2.sv
`default_nettype none

module bicubic_mult_stage2 import bicubic_pkg::*; #(
    parameter int LATENCY = MULT_LATENCY
) (
    input  wire logic         clk,
    input  wire logic         ena,
    input  wire weight_code_t weight,
    input  wire sample_t      pixel,
    output product_t          product
);

    weight_t  coef;
    product_t prod_d;

    assign coef   = weight_of(weight);
    // full signed product, sign extended before the multiply
    assign prod_d = product_t'(pixel) * product_t'(coef);

    if (LATENCY < 1 || LATENCY > 3) begin : g_bad_latency
        $error("bicubic_mult_stage2: LATENCY must be 1 to 3");
    end

    if (LATENCY == 1) begin : g_one
        product_t prod_q;

        always_ff @(posedge clk) begin
            if (ena) begin
                prod_q <= prod_d;
            end
        end

        assign product = prod_q;
    end else begin : g_pipe
        product_t prod_q [LATENCY];

        always_ff @(posedge clk) begin
            if (ena) begin
                prod_q[0] <= prod_d;
                for (int i = 1; i < LATENCY; i++) begin
                    prod_q[i] <= prod_q[i-1];
                end
            end
        end

        assign product = prod_q[LATENCY-1];
    end

endmodule

`default_nettype wire

// File: design/bicubic_pkg.sv
`default_nettype none

package bicubic_pkg;

    localparam int SAMPLE_W  = 24;
    localparam int CODE_W    = 3;
    localparam int WEIGHT_W  = 12;
    localparam int PRODUCT_W = 32;
    localparam int ACC_W     = 34;
    localparam int PIXEL_W   = 8;

    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    typedef logic        [CODE_W-1:0]    weight_code_t;
    typedef logic signed [WEIGHT_W-1:0]  weight_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic        [PIXEL_W-1:0]   pixel_t;
    typedef logic        [1:0]           phase_t;
    typedef logic        [1:0]           tap_t;

    localparam int NUM_TAPS     = 4;
    localparam int NUM_PHASES   = 4;
    localparam int MULT_LATENCY = 2;
    localparam int SUM_LATENCY  = 1;
    localparam int COEF_SHIFT   = 11;
    localparam int ROUND_BIAS   = 1024;

    // [phase][tap], tap 0 is the top row
    localparam weight_code_t DEFAULT_CODES [NUM_PHASES][NUM_TAPS] = '{
        '{3'd0, 3'd7, 3'd4, 3'd2},
        '{3'd1, 3'd5, 3'd6, 3'd3},
        '{3'd3, 3'd6, 3'd5, 3'd1},
        '{3'd2, 3'd4, 3'd7, 3'd0}
    };

    // fixed weight set, scaled by 2048
    function automatic weight_t weight_of(input weight_code_t code);
        case (code)
            3'd0:    return -weight_t'(21);
            3'd1:    return -weight_t'(135);
            3'd2:    return -weight_t'(147);
            3'd3:    return -weight_t'(225);
            3'd4:    return weight_t'(235);
            3'd5:    return weight_t'(873);
            3'd6:    return weight_t'(1535);
            default: return weight_t'(1981);
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/bicubic_sum_stage2.sv
`default_nettype none

module bicubic_sum_stage2 import bicubic_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic ena,
    product_if.sum    prods,
    output logic      out_valid,
    output pixel_t    out_pixel
);

    acc_t   acc;
    acc_t   biased;
    acc_t   scaled;
    pixel_t clipped;

    // four taps in acc_t so the sum cannot wrap
    assign acc = acc_t'(prods.p0) + acc_t'(prods.p1)
               + acc_t'(prods.p2) + acc_t'(prods.p3);

    assign biased = acc + acc_t'(ROUND_BIAS);
    assign scaled = biased >>> COEF_SHIFT;

    always_comb begin
        if (scaled < 0) begin
            clipped = '0;
        end else if (scaled > acc_t'(255)) begin
            clipped = 8'd255;
        end else begin
            clipped = scaled[PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            out_pixel <= clipped;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (ena) begin
            out_valid <= prods.valid;
        end
    end

    // an X on the valid pipe from the top would leak here a cycle later
    a_out_valid_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(out_valid)
    ) else $error("out_valid unknown after reset");

endmodule

`default_nettype wire

// File: design/bicubic_vert_filter.sv
`default_nettype none

module bicubic_vert_filter import bicubic_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         ena,
    input  wire logic         in_valid,
    input  wire phase_t       phase,
    input  wire sample_t      pix0,
    input  wire sample_t      pix1,
    input  wire sample_t      pix2,
    input  wire sample_t      pix3,
    input  wire logic         cfg_we,
    input  wire phase_t       cfg_phase,
    input  wire tap_t         cfg_tap,
    input  wire weight_code_t cfg_code,
    output logic              out_valid,
    output pixel_t            out_pixel
);

    tap_code_if codes_bus ();
    product_if  prod_bus ();

    logic [MULT_LATENCY-1:0] valid_pipe;

    assign codes_bus.phase = phase;

    bicubic_coef_regs u_coef_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_phase (cfg_phase),
        .cfg_tap   (cfg_tap),
        .cfg_code  (cfg_code),
        .codes     (codes_bus)
    );

    // one multiplier per tap, top row first
    bicubic_mult_stage2 #(.LATENCY(MULT_LATENCY)) u_mult0 (
        .clk     (clk),
        .ena     (ena),
        .weight  (codes_bus.code0),
        .pixel   (pix0),
        .product (prod_bus.p0)
    );

    bicubic_mult_stage2 #(.LATENCY(MULT_LATENCY)) u_mult1 (
        .clk     (clk),
        .ena     (ena),
        .weight  (codes_bus.code1),
        .pixel   (pix1),
        .product (prod_bus.p1)
    );

    bicubic_mult_stage2 #(.LATENCY(MULT_LATENCY)) u_mult2 (
        .clk     (clk),
        .ena     (ena),
        .weight  (codes_bus.code2),
        .pixel   (pix2),
        .product (prod_bus.p2)
    );

    bicubic_mult_stage2 #(.LATENCY(MULT_LATENCY)) u_mult3 (
        .clk     (clk),
        .ena     (ena),
        .weight  (codes_bus.code3),
        .pixel   (pix3),
        .product (prod_bus.p3)
    );

    // valid follows the products through the multiplier depth
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else if (ena) begin
            valid_pipe[0] <= in_valid;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign prod_bus.valid = valid_pipe[MULT_LATENCY-1];

    bicubic_sum_stage2 u_sum (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .prods     (prod_bus),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

`default_nettype wire

// File: sources.f
design/bicubic_pkg.sv
design/bicubic_ifs.sv
design/bicubic_coef_regs.sv
design/bicubic_mult_stage2.sv
design/bicubic_sum_stage2.sv
design/bicubic_vert_filter.sv
bench/tb_bicubic_vert_filter.sv
